// File: rv_lite.f
+incdir+include
rtl/rv_lite_pkg.sv
rtl/rv_issue_if.sv
rtl/rv_decode_stage.sv
rtl/rv_regfile.sv
rtl/rv_execute_stage.sv
rtl/rv_lite_top.sv
verification/tb_rv_lite.sv

// File: Bender.yml
package:
  name: rv_lite

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rv_lite_pkg.sv
      - rtl/rv_issue_if.sv
      - rtl/rv_decode_stage.sv
      - rtl/rv_regfile.sv
      - rtl/rv_execute_stage.sv
      - rtl/rv_lite_top.sv
  - target: test
    files:
      - verification/tb_rv_lite.sv

// File: verification/rv_lite_stimulus.txt
# columns, all hex: instruction word, illegal flag, expected rd, expected 64-bit value
# rd and value are don't-care (zero) on illegal lines
00628a33 0 14 0000000000000000
123450b7 0 01 0000000012345000
fff00113 0 02 ffffffffffffffff
002081b3 0 03 0000000012344fff
40100233 0 04 ffffffffedcbb000
03f11293 0 05 8000000000000000
03f2d313 0 06 0000000000000001
006093b3 0 07 000000002468a000
00003403 1 00 0000000000000000
0043c433 0 08 ffffffffc9a31000
003464b3 0 09 ffffffffdbb75fff
ff04f513 0 0a ffffffffdbb75ff0
55506593 0 0b 0000000000000555
fff5c613 0 0c fffffffffffffaaa
00a676b3 0 0d ffffffffdbb75aa0
00b6d733 0 0e 000007fffffffedd
00108033 0 00 000000002468a000
000067b3 0 0f 0000000000000000
021080b3 1 00 0000000000000000
00008893 0 11 0000000012345000

// File: verification/tb_rv_lite.sv
`default_nettype none

module tb_rv_lite;

    localparam int MAX_INSTR  = 64;
    localparam int WAIT_LIMIT = 50;

    logic                   clk;
    logic                   rst_n;
    logic                   instr_valid;
    rv_lite_pkg::instr_t    instr;
    logic                   illegal;
    logic                   wb_valid;
    rv_lite_pkg::reg_addr_t wb_rd;
    rv_lite_pkg::xlen_t     wb_data;

    rv_lite_pkg::instr_t    stim_instr [MAX_INSTR];
    logic                   stim_illegal [MAX_INSTR];
    rv_lite_pkg::reg_addr_t stim_rd [MAX_INSTR];
    rv_lite_pkg::xlen_t     stim_value [MAX_INSTR];
    int                     stim_count;

    int   exp_q [$]; // stimulus indices awaiting an outcome.
    int   errors;
    int   checked;
    int   pass_num;
    int   seed_ret;
    logic timed_out;

    rv_lite_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .illegal    (illegal),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic load_stimulus();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] word;
        logic [3:0]  flag;
        logic [7:0]  rd;
        logic [63:0] value;
        stim_count = 0;
        fd = $fopen("verification/rv_lite_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/rv_lite_stimulus.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && stim_count < MAX_INSTR) begin
            line = "";
            fields = $fgets(line, fd);
            fields = $sscanf(line, "%h %h %h %h", word, flag, rd, value);
            if (fields == 4) begin // header lines do not parse.
                stim_instr[stim_count]   = word;
                stim_illegal[stim_count] = (flag != 0);
                stim_rd[stim_count]      = rd[4:0];
                stim_value[stim_count]   = value;
                stim_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        int i;
        @(posedge clk);
        #5;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (i = 0; i < 6; i++) begin
            if (i == 4) begin
                @(posedge clk);
                #5;
                rst_n = 1'b1;
            end
            @(negedge clk);
            assert (!wb_valid && !illegal)
                else begin
                    $display("Outputs active around reset, cycle %0d", i);
                    errors++;
                end
        end
    endtask

    task automatic drive_pass(input logic random_gaps);
        int idx;
        int gap;
        int g;
        for (idx = 0; idx < stim_count; idx++) begin
            @(posedge clk);
            #5;
            instr_valid = 1'b1;
            instr       = stim_instr[idx];
            exp_q.push_back(idx);
            gap = random_gaps ? $urandom_range(2, 0) : 0;
            for (g = 0; g < gap; g++) begin
                @(posedge clk);
                #5;
                instr_valid = 1'b0;
                instr       = '0;
            end
        end
        @(posedge clk);
        #5;
        instr_valid = 1'b0;
        instr       = '0;
    endtask

    task automatic check_outcome(input logic is_illegal);
        int    idx;
        string name;
        if (exp_q.size() == 0) begin
            $display("An outcome appeared with no instruction outstanding");
            errors++;
            return;
        end
        idx  = exp_q.pop_front();
        name = $sformatf("pass%0d_instr%0d", pass_num, idx);
        checked++;
        assert (is_illegal == stim_illegal[idx])
            else begin
                $display("Error: %s illegal expected %0b actual %0b",
                         name, stim_illegal[idx], is_illegal);
                errors++;
            end
        if (!is_illegal && !stim_illegal[idx]) begin
            assert (wb_rd == stim_rd[idx])
                else begin
                    $display("Error: %s rd expected %0d actual %0d", name, stim_rd[idx], wb_rd);
                    errors++;
                end
            assert (wb_data == stim_value[idx])
                else begin
                    $display("Error: %s data expected %h actual %h",
                             name, stim_value[idx], wb_data);
                    errors++;
                end
        end
    endtask

    task automatic collect_pass();
        int handled;
        int idle;
        handled = 0;
        idle    = 0;
        while (handled < stim_count && idle < WAIT_LIMIT) begin
            @(negedge clk);
            idle++;
            if (wb_valid) begin // older of the two when both are high.
                check_outcome(1'b0);
                handled++;
                idle = 0;
            end
            if (illegal) begin
                check_outcome(1'b1);
                handled++;
                idle = 0;
            end
        end
        if (handled < stim_count) begin
            $display("Timed out waiting for an outcome, %0d of %0d seen", handled, stim_count);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_pass(input int num, input logic random_gaps);
        int cycles;
        pass_num = num;
        apply_reset();
        fork
            drive_pass(random_gaps);
            collect_pass();
        join
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (exp_q.size() == 0)
            else begin
                $display("Expected results left undrained: %0d", exp_q.size());
                errors++;
            end
        exp_q.delete();
        for (cycles = 0; cycles < 3; cycles++) begin
            @(negedge clk);
            assert (!wb_valid && !illegal)
                else begin
                    $display("Outcome seen after all instructions retired");
                    errors++;
                end
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        checked     = 0;
        pass_num    = 0;
        timed_out   = 1'b0;
        seed_ret    = $urandom(32'h7b77);
        load_stimulus();
        if (stim_count == 0) begin
            $display("No instructions were read from the stimulus file");
            errors++;
        end else begin
            run_pass(1, 1'b0); // back-to-back, hits forwarding and bypass.
            if (!timed_out)
                run_pass(2, 1'b1);
        end
        $display("Checked %0d outcomes, %0d errors", checked, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/rv_lite_top.sv
`default_nettype none

module rv_lite_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   instr_valid,
    input  wire rv_lite_pkg::instr_t    instr,
    output      logic                   illegal,
    output      logic                   wb_valid,
    output      rv_lite_pkg::reg_addr_t wb_rd,
    output      rv_lite_pkg::xlen_t     wb_data
);

    rv_lite_pkg::reg_addr_t rs1_addr;
    rv_lite_pkg::reg_addr_t rs2_addr;
    rv_lite_pkg::xlen_t     rs1_data;
    rv_lite_pkg::xlen_t     rs2_data;

    rv_issue_if u_issue (.clk(clk));

    rv_decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .illegal    (illegal),
        .issue      (u_issue.decode)
    );

    rv_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .wb_valid(wb_valid),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    // write-back feeds the port and the register file alike.
    rv_execute_stage u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (u_issue.execute),
        .wb_valid(wb_valid),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

endmodule

`default_nettype wire

// File: rtl/rv_execute_stage.sv
`default_nettype none

module rv_execute_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    rv_issue_if.execute                 issue,
    output      logic                   wb_valid,
    output      rv_lite_pkg::reg_addr_t wb_rd,
    output      rv_lite_pkg::xlen_t     wb_data
);

    logic               fwd_a;
    logic               fwd_b;
    rv_lite_pkg::xlen_t src_a;
    rv_lite_pkg::xlen_t src_b;
    rv_lite_pkg::xlen_t alu_res;
    logic [5:0]         shamt;

    // previous result still sits in write-back, not yet in the register file.
    assign fwd_a = wb_valid && wb_rd != '0 && wb_rd == issue.rs1;
    assign fwd_b = wb_valid && wb_rd != '0 && wb_rd == issue.rs2 && issue.use_rs2;

    assign src_a = fwd_a ? wb_data : issue.op_a;
    assign src_b = fwd_b ? wb_data : issue.op_b;
    assign shamt = src_b[5:0];

    always_comb begin
        case (issue.op)
            rv_lite_pkg::alu_add:    alu_res = src_a + src_b;
            rv_lite_pkg::alu_sub:    alu_res = src_a - src_b;
            rv_lite_pkg::alu_and:    alu_res = src_a & src_b;
            rv_lite_pkg::alu_or:     alu_res = src_a | src_b;
            rv_lite_pkg::alu_xor:    alu_res = src_a ^ src_b;
            rv_lite_pkg::alu_sll:    alu_res = src_a << shamt;
            rv_lite_pkg::alu_srl:    alu_res = src_a >> shamt; // logical only.
            rv_lite_pkg::alu_pass_b: alu_res = src_b;
            default:                 alu_res = src_a + src_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= issue.valid;
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            wb_rd   <= issue.rd;
            wb_data <= alu_res;
        end
    end

    a_wb_follows_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue.valid |=> wb_valid && wb_rd == $past(issue.rd));

    a_no_spurious_wb: assert property (@(posedge clk) disable iff (!rst_n)
        !issue.valid |=> !wb_valid);

endmodule

`default_nettype wire

// File: rtl/rv_regfile.sv
`default_nettype none

`include "rv_lite_defines.svh"

module rv_regfile (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire rv_lite_pkg::reg_addr_t rs1_addr,
    input  wire rv_lite_pkg::reg_addr_t rs2_addr,
    input  wire logic                   wb_valid,
    input  wire rv_lite_pkg::reg_addr_t wb_rd,
    input  wire rv_lite_pkg::xlen_t     wb_data,
    output      rv_lite_pkg::xlen_t     rs1_data,
    output      rv_lite_pkg::xlen_t     rs2_data
);

    rv_lite_pkg::xlen_t regs [1:`RV_REG_COUNT-1]; // x0 has no storage.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-through so decode sees the value retiring this cycle.
    assign rs1_data = (rs1_addr == '0)                   ? '0      :
                      (wb_valid && wb_rd == rs1_addr)    ? wb_data :
                                                           regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0)                   ? '0      :
                      (wb_valid && wb_rd == rs2_addr)    ? wb_data :
                                                           regs[rs2_addr];

    // a write to x0 must not reach any stored register.
    for (genvar r = 1; r < `RV_REG_COUNT; r++) begin : g_x0_write
        a_x0_no_store: assert property (@(posedge clk) disable iff (!rst_n)
            (wb_valid && wb_rd == '0) |=> $stable(regs[r]));
    end

endmodule

`default_nettype wire

// File: rtl/rv_decode_stage.sv
`default_nettype none

`include "rv_lite_defines.svh"

module rv_decode_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   instr_valid,
    input  wire rv_lite_pkg::instr_t    instr,
    input  wire rv_lite_pkg::xlen_t     rs1_data,
    input  wire rv_lite_pkg::xlen_t     rs2_data,
    output      rv_lite_pkg::reg_addr_t rs1_addr,
    output      rv_lite_pkg::reg_addr_t rs2_addr,
    output      logic                   illegal,
    rv_issue_if.decode                  issue
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    rv_lite_pkg::xlen_t   imm_i;
    rv_lite_pkg::xlen_t   imm_u;
    rv_lite_pkg::alu_op_e dec_op;
    logic                 dec_ok;
    logic                 dec_use_rs2;
    logic                 is_lui;

    function automatic logic f3_supported(logic [2:0] f3);
        return f3 inside {`RV_F3_ADD, `RV_F3_SLL, `RV_F3_XOR,
                          `RV_F3_SRL, `RV_F3_OR, `RV_F3_AND};
    endfunction

    function automatic rv_lite_pkg::alu_op_e f3_to_op(logic [2:0] f3);
        case (f3)
            `RV_F3_SLL: return rv_lite_pkg::alu_sll;
            `RV_F3_XOR: return rv_lite_pkg::alu_xor;
            `RV_F3_SRL: return rv_lite_pkg::alu_srl;
            `RV_F3_OR:  return rv_lite_pkg::alu_or;
            `RV_F3_AND: return rv_lite_pkg::alu_and;
            default:    return rv_lite_pkg::alu_add;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        dec_op      = f3_to_op(funct3);
        dec_ok      = 1'b0;
        dec_use_rs2 = 1'b0;
        is_lui      = 1'b0;
        case (opcode)
            `RV_OP_REG: begin
                dec_use_rs2 = 1'b1;
                dec_ok      = f3_supported(funct3) && (funct7 == 7'b0);
                if (funct3 == `RV_F3_ADD && funct7 == `RV_F7_SUB) begin
                    dec_op = rv_lite_pkg::alu_sub;
                    dec_ok = 1'b1;
                end
            end
            `RV_OP_IMM: begin
                dec_ok = f3_supported(funct3);
                if (funct3 == `RV_F3_SLL || funct3 == `RV_F3_SRL)
                    dec_ok = (funct7[6:1] == 6'b0); // srai and friends rejected.
            end
            `RV_OP_LUI: begin
                dec_op = rv_lite_pkg::alu_pass_b;
                dec_ok = 1'b1;
                is_lui = 1'b1;
            end
            default: dec_ok = 1'b0;
        endcase
    end

    assign rs1_addr = is_lui ? '0 : instr[19:15];
    assign rs2_addr = instr[24:20];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            issue.valid <= instr_valid && dec_ok;
            illegal     <= instr_valid && !dec_ok;
        end
    end

    // ID/EX payload.
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            issue.op      <= dec_op;
            issue.rd      <= instr[11:7];
            issue.rs1     <= rs1_addr;
            issue.rs2     <= rs2_addr;
            issue.use_rs2 <= dec_use_rs2;
            issue.op_a    <= rs1_data;
            issue.op_b    <= dec_use_rs2 ? rs2_data : (is_lui ? imm_u : imm_i);
        end
    end

    a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
        !(illegal && issue.valid));

endmodule

`default_nettype wire

// File: rtl/rv_issue_if.sv
`default_nettype none

interface rv_issue_if (
    input wire logic clk
);

    logic                  valid;
    rv_lite_pkg::alu_op_e  op;
    rv_lite_pkg::reg_addr_t rd;
    rv_lite_pkg::reg_addr_t rs1;
    rv_lite_pkg::reg_addr_t rs2;
    logic                  use_rs2;
    rv_lite_pkg::xlen_t    op_a;
    rv_lite_pkg::xlen_t    op_b;

    modport decode (
        output valid, op, rd, rs1, rs2, use_rs2, op_a, op_b
    );

    modport execute (
        input valid, op, rd, rs1, rs2, use_rs2, op_a, op_b
    );

    // payload must be settled whenever execute consumes it.
    a_issue_known: assert property (@(posedge clk)
        valid |-> !$isunknown({op, rd, rs1, rs2, use_rs2, op_a, op_b}));

endinterface

`default_nettype wire

// File: rtl/rv_lite_pkg.sv
`default_nettype none

`include "rv_lite_defines.svh"

package rv_lite_pkg;

    // one architectural word.
    typedef logic [`RV_XLEN-1:0] xlen_t;

    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;

    typedef logic [31:0] instr_t;

    // pass_b serves lui, op_b already holds the U immediate.
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_e;

endpackage

`default_nettype wire

// File: include/rv_lite_defines.svh
`ifndef RV_LITE_DEFINES_SVH
`define RV_LITE_DEFINES_SVH

// datapath width and register count fixed by RV64I.
`define RV_XLEN      64
`define RV_REG_COUNT 32

`define RV_OP_REG 7'b0110011
`define RV_OP_IMM 7'b0010011
`define RV_OP_LUI 7'b0110111

`define RV_F3_ADD 3'b000
`define RV_F3_SLL 3'b001
`define RV_F3_XOR 3'b100
`define RV_F3_SRL 3'b101
`define RV_F3_OR  3'b110
`define RV_F3_AND 3'b111

// funct7 of sub; all other supported forms use zero.
`define RV_F7_SUB 7'b0100000

`endif
